// ==== Makefile ====
SIM      := verilator
TOP      := dotp_tb
FILELIST := dotp.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dotp.f ====
source/dotp_pkg.sv
source/axi_reg_slice.sv
source/dotp_host_if.sv
source/dotp_rd_req.sv
source/dotp_rd_rsp.sv
source/dotp_mac.sv
source/dotp_top.sv
test/dotp_chk.sv
test/dotp_tb.sv

// ==== source/axi_reg_slice.sv ====
`timescale 1ns/1ps

module axi_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     sync_rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic [1:0] count_q;
  payload_t   head_q;
  payload_t   tail_q;
  logic       push;
  logic       pop;

  // Ready depends only on occupancy, so the input side is fully registered
  assign in_ready  = (count_q != 2'd2);
  assign out_valid = (count_q != 2'd0);
  assign out_data  = head_q;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      count_q <= 2'd0;
    end else if (push && !pop) begin
      count_q <= count_q + 2'd1;
    end else if (pop && !push) begin
      count_q <= count_q - 2'd1;
    end
  end

  // Head is what the consumer sees, tail is the skid entry
  always_ff @(posedge clk) begin
    if (pop) begin
      if (count_q == 2'd2) begin
        head_q <= tail_q;
      end else if (push) begin
        head_q <= in_data;
      end
    end else if (push) begin
      if (count_q == 2'd0) begin
        head_q <= in_data;
      end else begin
        tail_q <= in_data;
      end
    end
  end

endmodule

// ==== source/dotp_host_if.sv ====
`timescale 1ns/1ps

module dotp_host_if import dotp_pkg::*; (
  input  logic      clk,
  input  logic      sync_rst_n,
  input  logic      start_req,
  input  dotp_cmd_t cmd,
  output logic      start_ack,
  output acc_t      result,
  output logic      job_start,
  output dotp_cmd_t job_cmd,
  input  logic      acc_done,
  input  acc_t      acc_sum,
  input  logic      flr_assert,
  output logic      flr_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACKED
  } state_t;

  state_t state_q;
  logic   flr_assert_q;

  // --------------------------------------------------
  // Four-phase job handshake
  // --------------------------------------------------
  assign start_ack = (state_q == ST_ACKED);

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      state_q   <= ST_IDLE;
      job_start <= 1'b0;
      result    <= '0;
    end else begin
      job_start <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          // req was low when we left ACKED, so high here is a new job
          if (start_req) begin
            job_start <= 1'b1;
            state_q   <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (acc_done) begin
            result  <= acc_sum;
            state_q <= ST_ACKED;
          end
        end
        default: begin
          if (!start_req) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Command held for the engine for the whole job
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && start_req) begin
      job_cmd <= cmd;
    end
  end

  // --------------------------------------------------
  // Function reset response
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end else begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_assert_q && !flr_done;
    end
  end

endmodule

// ==== source/dotp_mac.sv ====
`timescale 1ns/1ps

module dotp_mac import dotp_pkg::*; #(
  parameter int VEC_LEN = 8
) (
  input  logic       clk,
  input  logic       sync_rst_n,
  input  logic       job_start,
  input  logic       pair_valid,
  input  prod_pair_t pair,
  output logic       acc_done,
  output acc_t       acc_sum
);

  acc_t prod_q;
  logic prod_valid_q;
  logic prod_last_q;
  acc_t acc_q;

  // Element index has to fit the lanes of one beat
  if (VEC_LEN < 2 || VEC_LEN > MAX_VEC_LEN) begin : g_vec_len_chk
    $error("dotp_mac: VEC_LEN must be in 2..%0d", MAX_VEC_LEN);
  end

  assign acc_sum = acc_q;

  // --------------------------------------------------
  // Stage 1: signed product
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      prod_valid_q <= 1'b0;
      prod_last_q  <= 1'b0;
    end else begin
      prod_valid_q <= pair_valid;
      prod_last_q  <= pair_valid && pair.last;
    end
  end

  always_ff @(posedge clk) begin
    prod_q <= acc_t'(pair.row) * acc_t'(pair.col);
  end

  // --------------------------------------------------
  // Stage 2: accumulate
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      acc_q    <= '0;
      acc_done <= 1'b0;
    end else begin
      acc_done <= prod_valid_q && prod_last_q;
      if (job_start) begin
        acc_q <= '0;
      end else if (prod_valid_q) begin
        acc_q <= acc_q + prod_q;
      end
    end
  end

endmodule

// ==== source/dotp_pkg.sv ====
package dotp_pkg;

  // --------------------------------------------------
  // Widths and limits
  // --------------------------------------------------
  localparam int ELEM_W      = 32;
  localparam int ACC_W       = 64;
  localparam int ADDR_W      = 64;
  // Lanes per read beat, upper bound for VEC_LEN
  localparam int MAX_VEC_LEN = 8;
  localparam int BEAT_W      = ELEM_W * MAX_VEC_LEN;

  // --------------------------------------------------
  // Scalar types
  // --------------------------------------------------
  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  // Lane k sits in 32-bit slot k
  typedef logic [BEAT_W-1:0]        beat_t;

  // --------------------------------------------------
  // Channel payloads
  // --------------------------------------------------
  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    beat_t data;
  } rd_rsp_t;

  typedef struct packed {
    addr_t row_addr;
    addr_t col_addr;
  } dotp_cmd_t;

  // One row/column element pair for the MAC
  typedef struct packed {
    elem_t row;
    elem_t col;
    logic  last;
  } prod_pair_t;

endpackage

// ==== source/dotp_rd_req.sv ====
`timescale 1ns/1ps

module dotp_rd_req import dotp_pkg::*; #(
  parameter int VEC_LEN    = 8,
  parameter int COL_STRIDE = 64
) (
  input  logic      clk,
  input  logic      sync_rst_n,
  input  logic      job_start,
  input  dotp_cmd_t job_cmd,
  output logic      req_valid,
  output rd_req_t   req,
  input  logic      req_ready
);

  localparam int CNT_W = $clog2(VEC_LEN);

  logic             row_phase_q;
  logic [CNT_W-1:0] col_cnt_q;
  rd_req_t          req_q;
  logic             req_fire;

  assign req_fire = req_valid && req_ready;
  assign req      = req_q;

  // --------------------------------------------------
  // Sequencing: one row read, then VEC_LEN column reads
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      req_valid   <= 1'b0;
      row_phase_q <= 1'b0;
      col_cnt_q   <= '0;
    end else if (job_start) begin
      req_valid   <= 1'b1;
      row_phase_q <= 1'b1;
      col_cnt_q   <= '0;
    end else if (req_fire) begin
      if (row_phase_q) begin
        row_phase_q <= 1'b0;
      end else if (col_cnt_q == CNT_W'(VEC_LEN - 1)) begin
        req_valid <= 1'b0;
      end else begin
        col_cnt_q <= col_cnt_q + 1'b1;
      end
    end
  end

  // Address only moves on a transfer, so it stays put across stalls
  always_ff @(posedge clk) begin
    if (job_start) begin
      req_q.addr <= job_cmd.row_addr;
    end else if (req_fire) begin
      if (row_phase_q) begin
        req_q.addr <= job_cmd.col_addr;
      end else begin
        req_q.addr <= req_q.addr + addr_t'(COL_STRIDE);
      end
    end
  end

endmodule

// ==== source/dotp_rd_rsp.sv ====
`timescale 1ns/1ps

module dotp_rd_rsp import dotp_pkg::*; #(
  parameter int VEC_LEN = 8
) (
  input  logic       clk,
  input  logic       sync_rst_n,
  input  logic       job_start,
  input  logic       rsp_valid,
  input  rd_rsp_t    rsp,
  output logic       rsp_ready,
  output logic       pair_valid,
  output prod_pair_t pair
);

  localparam int IDX_W = $clog2(VEC_LEN);

  elem_t            row_q [VEC_LEN];
  logic             want_row_q;
  logic [IDX_W-1:0] idx_q;
  logic             rsp_fire;
  logic             idx_last;

  // Never stalls, the slice in front absorbs memory timing
  assign rsp_ready = 1'b1;
  assign rsp_fire  = rsp_valid && rsp_ready;
  assign idx_last  = (idx_q == IDX_W'(VEC_LEN - 1));

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      want_row_q <= 1'b0;
      idx_q      <= '0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= 1'b0;
      if (job_start) begin
        want_row_q <= 1'b1;
        idx_q      <= '0;
      end else if (rsp_fire) begin
        if (want_row_q) begin
          want_row_q <= 1'b0;
        end else begin
          pair_valid <= 1'b1;
          idx_q      <= idx_last ? '0 : idx_q + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Row capture and column pairing
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rsp_fire && want_row_q) begin
      for (int i = 0; i < VEC_LEN; i++) begin
        row_q[i] <= elem_t'(rsp.data[i*ELEM_W +: ELEM_W]);
      end
    end
    if (rsp_fire && !want_row_q) begin
      // column element always arrives in lane 0
      pair.row  <= row_q[idx_q];
      pair.col  <= elem_t'(rsp.data[ELEM_W-1:0]);
      pair.last <= idx_last;
    end
  end

endmodule

// ==== source/dotp_top.sv ====
`timescale 1ns/1ps

module dotp_top import dotp_pkg::*; #(
  parameter int VEC_LEN    = 8,
  parameter int COL_STRIDE = 64
) (
  input  logic      clk,
  input  logic      sync_rst_n,
  // Host job port
  input  logic      start_req,
  input  dotp_cmd_t cmd,
  output logic      start_ack,
  output acc_t      result,
  // Memory read channel
  output logic      mem_ar_valid,
  output rd_req_t   mem_ar,
  input  logic      mem_ar_ready,
  input  logic      mem_r_valid,
  input  rd_rsp_t   mem_r,
  output logic      mem_r_ready,
  // Function reset
  input  logic      flr_assert,
  output logic      flr_done
);

  logic       job_start;
  dotp_cmd_t  job_cmd;
  logic       acc_done;
  acc_t       acc_sum;
  logic       req_valid;
  logic       req_ready;
  rd_req_t    req;
  logic       rsp_valid;
  logic       rsp_ready;
  rd_rsp_t    rsp;
  logic       pair_valid;
  prod_pair_t pair;

  dotp_host_if u_host_if (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .start_req  (start_req),
    .cmd        (cmd),
    .start_ack  (start_ack),
    .result     (result),
    .job_start  (job_start),
    .job_cmd    (job_cmd),
    .acc_done   (acc_done),
    .acc_sum    (acc_sum),
    .flr_assert (flr_assert),
    .flr_done   (flr_done)
  );

  // --------------------------------------------------
  // Request path
  // --------------------------------------------------
  dotp_rd_req #(
    .VEC_LEN    (VEC_LEN),
    .COL_STRIDE (COL_STRIDE)
  ) u_rd_req (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .job_start  (job_start),
    .job_cmd    (job_cmd),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready)
  );

  axi_reg_slice #(
    .payload_t (rd_req_t)
  ) u_ar_slice (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .in_valid   (req_valid),
    .in_data    (req),
    .in_ready   (req_ready),
    .out_valid  (mem_ar_valid),
    .out_data   (mem_ar),
    .out_ready  (mem_ar_ready)
  );

  // --------------------------------------------------
  // Response path and MAC
  // --------------------------------------------------
  axi_reg_slice #(
    .payload_t (rd_rsp_t)
  ) u_r_slice (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .in_valid   (mem_r_valid),
    .in_data    (mem_r),
    .in_ready   (mem_r_ready),
    .out_valid  (rsp_valid),
    .out_data   (rsp),
    .out_ready  (rsp_ready)
  );

  dotp_rd_rsp #(
    .VEC_LEN (VEC_LEN)
  ) u_rd_rsp (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .job_start  (job_start),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_ready  (rsp_ready),
    .pair_valid (pair_valid),
    .pair       (pair)
  );

  dotp_mac #(
    .VEC_LEN (VEC_LEN)
  ) u_mac (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .job_start  (job_start),
    .pair_valid (pair_valid),
    .pair       (pair),
    .acc_done   (acc_done),
    .acc_sum    (acc_sum)
  );

endmodule

// ==== test/dotp_chk.sv ====
`timescale 1ns/1ps

module dotp_chk import dotp_pkg::*; (
  input logic    clk,
  input logic    sync_rst_n,
  input logic    start_req,
  input logic    start_ack,
  input logic    mem_ar_valid,
  input logic    mem_ar_ready,
  input rd_req_t mem_ar
);

  // Count of failed assertions, read at the end of the run
  int fail_cnt = 0;

  // --------------------------------------------------
  // Host handshake
  // --------------------------------------------------
  ack_rise_chk: assert property (@(posedge clk) disable iff (!sync_rst_n)
    !start_req && !start_ack |=> !start_ack)
  else begin
    fail_cnt++;
    $error("start_ack rose while start_req was low");
  end

  ack_hold_chk: assert property (@(posedge clk) disable iff (!sync_rst_n)
    start_req && start_ack |=> start_ack)
  else begin
    fail_cnt++;
    $error("start_ack dropped while start_req was still high");
  end

  ack_fall_chk: assert property (@(posedge clk) disable iff (!sync_rst_n)
    start_ack && !start_req |=> !start_ack)
  else begin
    fail_cnt++;
    $error("start_ack did not fall one cycle after start_req went low");
  end

  // --------------------------------------------------
  // Read request channel
  // --------------------------------------------------
  ar_stable_chk: assert property (@(posedge clk) disable iff (!sync_rst_n)
    mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar))
  else begin
    fail_cnt++;
    $error("mem_ar changed or was withdrawn during a stall");
  end

endmodule

bind dotp_top dotp_chk u_dotp_chk (
  .clk          (clk),
  .sync_rst_n   (sync_rst_n),
  .start_req    (start_req),
  .start_ack    (start_ack),
  .mem_ar_valid (mem_ar_valid),
  .mem_ar_ready (mem_ar_ready),
  .mem_ar       (mem_ar)
);

// ==== test/dotp_tb.sv ====
`timescale 1ns/1ps

module dotp_tb import dotp_pkg::*; ();

  localparam int VEC_LEN        = 8;
  localparam int COL_STRIDE     = 64;
  localparam int MEM_AW         = 10;
  localparam int MEM_WORDS      = 1 << MEM_AW;
  localparam int NUM_JOBS       = 20;
  localparam int CYCLES_PER_JOB = 200;
  localparam int TIMEOUT_CYCLES = NUM_JOBS * CYCLES_PER_JOB;
  localparam logic [31:0] LFSR_SEED = 32'd69892;

  // Directed vectors, lane k in slot k
  localparam int DIR_ROW_WORD = 64;
  localparam int DIR_COL_WORD = 512;
  localparam logic [255:0] DIR_ROW = {32'h0000_0002, 32'h0000_0000, 32'hffff_2bcf,
                                      32'h0000_3039, 32'h0000_0001, 32'hffff_ffff,
                                      32'h8000_0000, 32'h7fff_ffff};
  localparam logic [255:0] DIR_COL = {32'h7fff_ffff, 32'h0000_0063, 32'h0000_03e8,
                                      32'hffff_fffd, 32'hffff_ffff, 32'h0000_0007,
                                      32'h8000_0000, 32'h8000_0000};

  logic        clk = 1'b0;
  logic        sync_rst_n;
  logic        start_req;
  dotp_cmd_t   cmd;
  logic        start_ack;
  acc_t        result;
  logic        mem_ar_valid;
  rd_req_t     mem_ar;
  logic        mem_ar_ready = 1'b0;
  logic        mem_r_valid  = 1'b0;
  rd_rsp_t     mem_r        = '0;
  logic        mem_r_ready;
  logic        flr_assert;
  logic        flr_done;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] stim_lfsr = LFSR_SEED;
  logic [31:0] bus_lfsr  = LFSR_SEED;
  logic        stall_en  = 1'b0;
  logic        ack_seen  = 1'b0;
  int          cycle_cnt = 0;
  addr_t       exp_addr [$];
  addr_t       rsp_q [$];
  acc_t        exp_result [$];
  string       job_names [$];

  dotp_top #(
    .VEC_LEN    (VEC_LEN),
    .COL_STRIDE (COL_STRIDE)
  ) u_dotp_top (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .start_req    (start_req),
    .cmd          (cmd),
    .start_ack    (start_ack),
    .result       (result),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar       (mem_ar),
    .mem_ar_ready (mem_ar_ready),
    .mem_r_valid  (mem_r_valid),
    .mem_r        (mem_r),
    .mem_r_ready  (mem_r_ready),
    .flr_assert   (flr_assert),
    .flr_done     (flr_done)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------
  // Random source and memory helpers
  // --------------------------------------------------
  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_word(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
  endtask

  function automatic elem_t word_at(input addr_t a);
    return elem_t'(mem[a[MEM_AW+1:2]]);
  endfunction

  function automatic rd_rsp_t build_beat(input addr_t a);
    rd_rsp_t b;
    for (int k = 0; k < MAX_VEC_LEN; k++) begin
      b.data[k*ELEM_W +: ELEM_W] = word_at(a + addr_t'(4 * k));
    end
    return b;
  endfunction

  // Expected dot product straight from the memory contents
  function automatic acc_t ref_dot(input dotp_cmd_t c);
    acc_t  sum;
    elem_t r;
    elem_t q;
    sum = '0;
    for (int k = 0; k < VEC_LEN; k++) begin
      r = word_at(c.row_addr + addr_t'(4 * k));
      q = word_at(c.col_addr + addr_t'(COL_STRIDE * k));
      sum = sum + acc_t'(r) * acc_t'(q);
    end
    return sum;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_acc(input string name, input acc_t exp, input acc_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      stop_on_failure();
    end
  endtask

  // --------------------------------------------------
  // Memory model with random stalls and gaps
  // --------------------------------------------------
  always @(posedge clk) begin
    if (mem_ar_valid && mem_ar_ready) begin
      if (exp_addr.size() == 0) begin
        $display("Read request to %h arrived when no request was expected", mem_ar.addr);
        stop_on_failure();
      end else begin
        check_addr("read request address", exp_addr.pop_front(), mem_ar.addr);
        rsp_q.push_back(mem_ar.addr);
      end
    end
    bus_lfsr = lfsr_step(bus_lfsr);
    mem_ar_ready <= !stall_en || bus_lfsr[0];
    if (!mem_r_valid || mem_r_ready) begin
      bus_lfsr = lfsr_step(bus_lfsr);
      if (rsp_q.size() != 0 && (!stall_en || bus_lfsr[0])) begin
        mem_r_valid <= 1'b1;
        mem_r       <= build_beat(rsp_q.pop_front());
      end else begin
        mem_r_valid <= 1'b0;
      end
    end
  end

  // Result compare on each rising start_ack
  always @(negedge clk) begin
    if (start_ack && !ack_seen) begin
      if (exp_result.size() == 0) begin
        $display("start_ack rose with no job outstanding");
        stop_on_failure();
      end else begin
        check_acc(job_names.pop_front(), exp_result.pop_front(), result);
        check_bit("all read requests accepted", 1'b1, exp_addr.size() == 0);
      end
    end
    ack_seen = start_ack;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

  // --------------------------------------------------
  // Job sequencing
  // --------------------------------------------------
  task automatic rand_cmd(output dotp_cmd_t c);
    logic [31:0] hi;
    logic [31:0] lo;
    rand_word(32, hi);
    rand_word(9, lo);
    c.row_addr = {hi, 21'h0, lo[8:0], 2'b00};
    rand_word(32, hi);
    rand_word(8, lo);
    // Columns in the upper half of the model
    c.col_addr = {hi, 20'h0, 2'b10, lo[7:0], 2'b00};
  endtask

  task automatic queue_job(input string name, input dotp_cmd_t c);
    job_names.push_back(name);
    exp_result.push_back(ref_dot(c));
    exp_addr.push_back(c.row_addr);
    for (int k = 0; k < VEC_LEN; k++) begin
      exp_addr.push_back(c.col_addr + addr_t'(COL_STRIDE * k));
    end
  endtask

  task automatic start_job(input dotp_cmd_t c);
    @(posedge clk);
    start_req <= 1'b1;
    cmd       <= c;
  endtask

  task automatic wait_for_ack();
    @(negedge clk);
    while (!start_ack) begin
      @(negedge clk);
    end
  endtask

  task automatic release_job();
    @(posedge clk);
    start_req <= 1'b0;
    // Low level is first sampled at the next edge
    @(negedge clk);
    check_bit("start_ack before req seen low", 1'b1, start_ack);
    @(negedge clk);
    check_bit("start_ack one cycle after req low", 1'b0, start_ack);
  endtask

  task automatic run_job(input string name, input dotp_cmd_t c);
    queue_job(name, c);
    start_job(c);
    wait_for_ack();
    release_job();
  endtask

  initial begin
    dotp_cmd_t   c;
    acc_t        held;
    logic [31:0] w;
    sync_rst_n = 1'b0;
    start_req  = 1'b0;
    cmd        = '0;
    flr_assert = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      rand_word(32, w);
      mem[i] = w;
    end
    for (int k = 0; k < VEC_LEN; k++) begin
      mem[DIR_ROW_WORD + k] = DIR_ROW[k*32 +: 32];
      mem[DIR_COL_WORD + k * (COL_STRIDE / 4)] = DIR_COL[k*32 +: 32];
    end

    repeat (2) @(posedge clk);
    sync_rst_n <= 1'b1;
    @(negedge clk);
    check_bit("start_ack after reset", 1'b0, start_ack);
    check_bit("mem_ar_valid after reset", 1'b0, mem_ar_valid);
    check_bit("flr_done after reset", 1'b0, flr_done);
    check_bit("mem_r_ready after reset", 1'b1, mem_r_ready);

    c.row_addr = addr_t'(4 * DIR_ROW_WORD);
    c.col_addr = addr_t'(4 * DIR_COL_WORD);
    run_job("directed extremes", c);

    for (int j = 0; j < 12; j++) begin
      rand_cmd(c);
      run_job($sformatf("random job %0d", j), c);
    end

    stall_en = 1'b1;
    for (int j = 0; j < 5; j++) begin
      rand_cmd(c);
      run_job($sformatf("stalled job %0d", j), c);
    end
    stall_en = 1'b0;

    // Request held well past the ack
    rand_cmd(c);
    queue_job("held request job", c);
    held = ref_dot(c);
    start_job(c);
    wait_for_ack();
    repeat (6) begin
      @(negedge clk);
      check_bit("start_ack while req held", 1'b1, start_ack);
      check_acc("result while req held", held, result);
    end
    release_job();
    rand_cmd(c);
    run_job("job after held request", c);

    // Function reset pulse
    @(posedge clk);
    flr_assert <= 1'b1;
    @(posedge clk);
    flr_assert <= 1'b0;
    @(negedge clk);
    check_bit("flr_done at sampling edge", 1'b0, flr_done);
    @(negedge clk);
    check_bit("flr_done two cycles later", 1'b1, flr_done);
    @(negedge clk);
    check_bit("flr_done pulse width", 1'b0, flr_done);

    repeat (4) @(negedge clk);
    check_bit("no result outstanding", 1'b1, exp_result.size() == 0);
    if (u_dotp_top.u_dotp_chk.fail_cnt != 0) begin
      $display("%0d assertion failures seen", u_dotp_top.u_dotp_chk.fail_cnt);
      stop_on_failure();
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
